// File: rtl/cache_array.sv
`timescale 1ns/1ps

module cache_array (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         enable,
	input  logic [mem_pkg::INDEX_W-1:0]  index,
	input  logic [mem_pkg::OFFSET_W-1:0] offset,
	input  logic                         cmp,
	input  logic                         wr_cache,
	input  logic [mem_pkg::TAG_W-1:0]    tag_in,
	input  logic [mem_pkg::DATA_W-1:0]   data_in_ct,
	input  logic                         valid_in,
	output logic                         hit,
	output logic                         dirty,
	output logic                         valid,
	output logic [mem_pkg::TAG_W-1:0]    tag_out,
	output logic [mem_pkg::DATA_W-1:0]   data_out_cache
);
	import mem_pkg::*;

	logic [NUM_SETS-1:0] valid_bits;
	logic [NUM_SETS-1:0] dirty_bits;
	logic [TAG_W-1:0] tags [NUM_SETS];
	logic [DATA_W-1:0] words [NUM_SETS][WORDS_PER_BLOCK];

	logic do_fill;
	logic do_write;

	assign tag_out = tags[index];
	assign valid = valid_bits[index];
	assign dirty = dirty_bits[index];
	assign data_out_cache = words[index][offset];
	assign hit = cmp && valid && (tags[index] == tag_in);

	// Fill writes ignore the tag, compare writes need a hit
	assign do_fill = enable && wr_cache && !cmp;
	assign do_write = do_fill || (enable && wr_cache && hit);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end
		else if (do_fill)
		begin
			valid_bits[index] <= valid_in;
			dirty_bits[index] <= 1'b0;
		end
		else if (do_write)
			dirty_bits[index] <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (do_fill)
			tags[index] <= tag_in;
		if (do_write)
			words[index][offset] <= data_in_ct;
	end

	a_write_enabled: assert property (@(posedge clk) disable iff (rst)
		wr_cache |-> enable);

endmodule

// File: rtl/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [mem_pkg::ADDR_W-1:0]   addr,
	input  logic [mem_pkg::DATA_W-1:0]   data_in,
	input  logic                         rd,
	input  logic                         wr,
	input  logic                         hit,
	input  logic                         dirty,
	input  logic                         valid,
	input  logic [mem_pkg::TAG_W-1:0]    tag_out,
	input  logic [mem_pkg::DATA_W-1:0]   data_out_cache,
	input  logic                         mem_gnt,
	input  logic [mem_pkg::DATA_W-1:0]   mem_rdata,
	output logic                         enable,
	output logic [mem_pkg::INDEX_W-1:0]  index,
	output logic [mem_pkg::OFFSET_W-1:0] offset,
	output logic                         cmp,
	output logic                         wr_cache,
	output logic [mem_pkg::TAG_W-1:0]    tag_in,
	output logic [mem_pkg::DATA_W-1:0]   data_in_ct,
	output logic                         valid_in,
	output logic                         mem_req,
	output logic [mem_pkg::ADDR_W-1:0]   mem_addr,
	output logic [mem_pkg::DATA_W-1:0]   mem_wdata,
	output logic                         mem_wr,
	output logic                         mem_rd,
	output logic [mem_pkg::DATA_W-1:0]   data_out,
	output logic                         done,
	output logic                         cache_hit,
	output logic                         stall,
	output logic                         err
);
	import mem_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;
	logic state_err;

	logic [TAG_W-1:0] req_tag;
	logic [INDEX_W-1:0] req_index;
	logic [OFFSET_W-1:0] req_word;
	logic [OFFSET_W-1:0] wb_word;
	logic [OFFSET_W-1:0] fill_rd_word;
	logic [OFFSET_W-1:0] fill_wr_word;

	assign req_tag = addr[ADDR_W-1 -: TAG_W];
	assign req_index = addr[ADDR_W-TAG_W-1 -: INDEX_W];
	assign req_word = addr[OFFSET_W:1];

	// Word being moved in each burst state
	assign wb_word = OFFSET_W'(state - WB0);
	assign fill_rd_word = OFFSET_W'(state - FILL0);
	assign fill_wr_word = OFFSET_W'(state - FILL2);

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb
	begin
		enable = 1'b0;
		index = req_index;
		offset = req_word;
		cmp = 1'b0;
		wr_cache = 1'b0;
		tag_in = req_tag;
		data_in_ct = data_in;
		valid_in = 1'b0;
		mem_req = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		mem_wr = 1'b0;
		mem_rd = 1'b0;
		data_out = '0;
		done = 1'b0;
		cache_hit = 1'b0;
		stall = 1'b1;
		state_err = 1'b0;
		next_state = state;

		case (state)
			IDLE:
			begin
				stall = 1'b0;
				if (rd)
					next_state = CMP_RD;
				else if (wr)
					next_state = CMP_WT;
			end
			CMP_RD:
			begin
				enable = 1'b1;
				cmp = 1'b1;
				next_state = hit ? HIT : REQ;
			end
			CMP_WT:
			begin
				// Array only takes the word on a tag hit
				enable = 1'b1;
				cmp = 1'b1;
				wr_cache = 1'b1;
				next_state = hit ? HIT : REQ;
			end
			HIT:
			begin
				enable = 1'b1;
				data_out = data_out_cache;
				done = 1'b1;
				cache_hit = 1'b1;
				next_state = IDLE;
			end
			REQ:
			begin
				enable = 1'b1;
				mem_req = 1'b1;
				if (mem_gnt)
					next_state = (dirty && valid) ? WB0 : FILL0;
			end
			WB0, WB1, WB2, WB3:
			begin
				// Victim block goes back under its old tag
				enable = 1'b1;
				offset = wb_word;
				mem_req = 1'b1;
				mem_wr = 1'b1;
				mem_addr = {tag_out, req_index, wb_word, 1'b0};
				mem_wdata = data_out_cache;
				next_state = ctrl_state_t'(state + 4'd1);
			end
			FILL0, FILL1, FILL2, FILL3, FILL4, FILL5:
			begin
				enable = 1'b1;
				mem_req = 1'b1;
				if (state <= FILL3)
				begin
					mem_rd = 1'b1;
					mem_addr = {req_tag, req_index, fill_rd_word, 1'b0};
				end
				// Read data lands MEM_LATENCY states after its strobe
				if (state >= FILL2)
				begin
					wr_cache = 1'b1;
					valid_in = 1'b1;
					offset = fill_wr_word;
					data_in_ct = mem_rdata;
				end
				next_state = ctrl_state_t'(state + 4'd1);
			end
			RETRY:
			begin
				enable = 1'b1;
				cmp = 1'b1;
				wr_cache = wr && !rd;
				data_out = data_out_cache;
				done = 1'b1;
				next_state = IDLE;
			end
			default:
			begin
				state_err = 1'b1;
				next_state = IDLE;
			end
		endcase
	end

	assign err = (rd && wr) || state_err;

	a_single_strobe: assert property (@(posedge clk) disable iff (rst)
		!(mem_wr && mem_rd));

	// Arbiter must already hold this port when a strobe goes out
	a_strobe_granted: assert property (@(posedge clk) disable iff (rst)
		(mem_rd || mem_wr) |-> mem_gnt);

endmodule

// File: rtl/four_bank_mem.sv
`timescale 1ns/1ps

module four_bank_mem (
	input  logic                       clk,
	input  logic [mem_pkg::ADDR_W-1:0] addr,
	input  logic [mem_pkg::DATA_W-1:0] data_in,
	input  logic                       wr,
	input  logic                       rd,
	output logic [mem_pkg::DATA_W-1:0] data_out
);
	import mem_pkg::*;

	logic [OFFSET_W-1:0] bank_sel;
	logic [TAG_W+INDEX_W-1:0] row;
	logic [DATA_W-1:0] bank_q [WORDS_PER_BLOCK];
	logic [DATA_W-1:0] rd_pipe [MEM_LATENCY];

	assign bank_sel = addr[OFFSET_W:1];
	assign row = addr[ADDR_W-1:OFFSET_W+1];

	for (genvar b = 0; b < WORDS_PER_BLOCK; b++)
	begin : g_bank
		logic [DATA_W-1:0] mem [BANK_DEPTH];

		always_ff @(posedge clk)
		begin
			if (wr && bank_sel == OFFSET_W'(b))
				mem[row] <= data_in;
		end

		assign bank_q[b] = mem[row];
	end

	// Several reads may be in flight, one per stage
	always_ff @(posedge clk)
	begin
		rd_pipe[0] <= rd ? bank_q[bank_sel] : '0;
		for (int i = 1; i < MEM_LATENCY; i++)
			rd_pipe[i] <= rd_pipe[i-1];
	end

	assign data_out = rd_pipe[MEM_LATENCY-1];

endmodule

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [mem_pkg::NUM_PORTS-1:0] req,
	output logic [mem_pkg::NUM_PORTS-1:0] gnt
);
	import mem_pkg::*;

	localparam int PTR_W = $clog2(NUM_PORTS);

	logic [PTR_W-1:0] last;
	logic [PTR_W-1:0] pick_idx;
	logic [NUM_PORTS-1:0] pick;

	// Search starts just past the last winner
	always_comb
	begin
		int cand;
		pick = '0;
		pick_idx = last;
		for (int i = 1; i <= NUM_PORTS; i++)
		begin
			cand = (int'(last) + i) % NUM_PORTS;
			if (req[cand] && pick == '0)
			begin
				pick[cand] = 1'b1;
				pick_idx = PTR_W'(cand);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			gnt <= '0;
			last <= PTR_W'(NUM_PORTS - 1);
		end
		else if ((gnt & req) == '0)
		begin
			gnt <= pick;
			if (pick != '0)
				last <= pick_idx;
		end
	end

	a_gnt_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt));

endmodule

// File: rtl/mem_pkg.sv
package mem_pkg;

	// Byte address, word data
	localparam int ADDR_W = 16;
	localparam int DATA_W = 16;

	// Tag addr[15:11], index addr[10:3], word offset addr[2:1]
	localparam int TAG_W = 5;
	localparam int INDEX_W = 8;
	localparam int WORDS_PER_BLOCK = 4;
	localparam int OFFSET_W = $clog2(WORDS_PER_BLOCK);
	localparam int NUM_SETS = 1 << INDEX_W;

	// Each bank holds one word of every block
	localparam int BANK_DEPTH = 1 << (TAG_W + INDEX_W);

	// Read strobe to data on the memory output
	localparam int MEM_LATENCY = 2;

	localparam int NUM_PORTS = 2;

	// Writeback and fill states stay contiguous, the FSM steps through them by increment
	typedef enum logic [3:0] {
		IDLE   = 4'd0,
		CMP_RD = 4'd1,
		CMP_WT = 4'd2,
		HIT    = 4'd3,
		REQ    = 4'd4,
		WB0    = 4'd5,
		WB1    = 4'd6,
		WB2    = 4'd7,
		WB3    = 4'd8,
		FILL0  = 4'd9,
		FILL1  = 4'd10,
		FILL2  = 4'd11,
		FILL3  = 4'd12,
		FILL4  = 4'd13,
		FILL5  = 4'd14,
		RETRY  = 4'd15
	} ctrl_state_t;

endpackage

// File: rtl/mem_system.sv
`timescale 1ns/1ps

module mem_system (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [mem_pkg::ADDR_W-1:0] p0_addr,
	input  logic [mem_pkg::DATA_W-1:0] p0_data_in,
	input  logic                       p0_rd,
	input  logic                       p0_wr,
	output logic [mem_pkg::DATA_W-1:0] p0_data_out,
	output logic                       p0_done,
	output logic                       p0_cache_hit,
	output logic                       p0_stall,
	output logic                       p0_err,
	input  logic [mem_pkg::ADDR_W-1:0] p1_addr,
	input  logic [mem_pkg::DATA_W-1:0] p1_data_in,
	input  logic                       p1_rd,
	input  logic                       p1_wr,
	output logic [mem_pkg::DATA_W-1:0] p1_data_out,
	output logic                       p1_done,
	output logic                       p1_cache_hit,
	output logic                       p1_stall,
	output logic                       p1_err
);
	import mem_pkg::*;

	logic [NUM_PORTS-1:0][ADDR_W-1:0] addr_v;
	logic [NUM_PORTS-1:0][DATA_W-1:0] data_in_v;
	logic [NUM_PORTS-1:0][DATA_W-1:0] data_out_v;
	logic [NUM_PORTS-1:0] rd_v, wr_v, done_v, cache_hit_v, stall_v, err_v;
	logic [NUM_PORTS-1:0] mem_req_v, mem_gnt_v, mem_wr_v, mem_rd_v;
	logic [NUM_PORTS-1:0][ADDR_W-1:0] mem_addr_v;
	logic [NUM_PORTS-1:0][DATA_W-1:0] mem_wdata_v;

	logic [ADDR_W-1:0] mem_addr;
	logic [DATA_W-1:0] mem_wdata;
	logic [DATA_W-1:0] mem_rdata;
	logic mem_wr;
	logic mem_rd;

	assign addr_v = {p1_addr, p0_addr};
	assign data_in_v = {p1_data_in, p0_data_in};
	assign rd_v = {p1_rd, p0_rd};
	assign wr_v = {p1_wr, p0_wr};
	assign {p1_data_out, p0_data_out} = data_out_v;
	assign {p1_done, p0_done} = done_v;
	assign {p1_cache_hit, p0_cache_hit} = cache_hit_v;
	assign {p1_stall, p0_stall} = stall_v;
	assign {p1_err, p0_err} = err_v;

	for (genvar p = 0; p < NUM_PORTS; p++)
	begin : g_port
		logic enable, cmp, wr_cache, valid_in, hit, dirty, valid;
		logic [INDEX_W-1:0] index;
		logic [OFFSET_W-1:0] offset;
		logic [TAG_W-1:0] tag_in, tag_out;
		logic [DATA_W-1:0] data_in_ct, data_out_cache;

		cache_ctrl u_ctrl (
			.clk, .rst,
			.addr(addr_v[p]), .data_in(data_in_v[p]), .rd(rd_v[p]), .wr(wr_v[p]),
			.hit, .dirty, .valid, .tag_out, .data_out_cache,
			.mem_gnt(mem_gnt_v[p]), .mem_rdata,
			.enable, .index, .offset, .cmp, .wr_cache, .tag_in, .data_in_ct, .valid_in,
			.mem_req(mem_req_v[p]), .mem_addr(mem_addr_v[p]), .mem_wdata(mem_wdata_v[p]),
			.mem_wr(mem_wr_v[p]), .mem_rd(mem_rd_v[p]),
			.data_out(data_out_v[p]), .done(done_v[p]), .cache_hit(cache_hit_v[p]),
			.stall(stall_v[p]), .err(err_v[p])
		);

		cache_array u_array (
			.clk, .rst, .enable, .index, .offset, .cmp, .wr_cache, .tag_in,
			.data_in_ct, .valid_in, .hit, .dirty, .valid, .tag_out, .data_out_cache
		);
	end

	mem_arbiter u_arb (.clk, .rst, .req(mem_req_v), .gnt(mem_gnt_v));

	// Granted port drives memory, read data fans out to both
	assign mem_addr = mem_gnt_v[1] ? mem_addr_v[1] : mem_addr_v[0];
	assign mem_wdata = mem_gnt_v[1] ? mem_wdata_v[1] : mem_wdata_v[0];
	assign mem_wr = |(mem_wr_v & mem_gnt_v);
	assign mem_rd = |(mem_rd_v & mem_gnt_v);

	four_bank_mem u_mem (
		.clk, .addr(mem_addr), .data_in(mem_wdata),
		.wr(mem_wr), .rd(mem_rd), .data_out(mem_rdata)
	);

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the mem_system testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 -f sim.f --top-module tb_mem_system
./obj_dir/Vtb_mem_system > sim.log || true
cat sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: sim.f
rtl/mem_pkg.sv
rtl/cache_array.sv
rtl/cache_ctrl.sv
rtl/four_bank_mem.sv
rtl/mem_arbiter.sv
rtl/mem_system.sv
sim/tb_mem_system.sv

// File: sim/tb_mem_system.sv
`timescale 1ns/1ps

module tb_mem_system;
	import mem_pkg::*;

	logic clk;
	logic rst;
	logic [ADDR_W-1:0] p0_addr;
	logic [DATA_W-1:0] p0_data_in;
	logic p0_rd;
	logic p0_wr;
	logic [DATA_W-1:0] p0_data_out;
	logic p0_done;
	logic p0_cache_hit;
	logic p0_stall;
	logic p0_err;
	logic [ADDR_W-1:0] p1_addr;
	logic [DATA_W-1:0] p1_data_in;
	logic p1_rd;
	logic p1_wr;
	logic [DATA_W-1:0] p1_data_out;
	logic p1_done;
	logic p1_cache_hit;
	logic p1_stall;
	logic p1_err;

	// Reference memory by word address and per-port tag shadows to predict hits
	logic [DATA_W-1:0] ref_mem [1 << (ADDR_W - 1)];
	logic [255:0] shadow_valid [2];
	logic [TAG_W-1:0] shadow_tag [2][256];

	integer seed;
	int errors;
	int accesses;

	mem_system DUT (.*);

	always #2 clk = ~clk;

	function automatic logic done_of(input bit p);
		return p ? p1_done : p0_done;
	endfunction

	function automatic logic hit_of(input bit p);
		return p ? p1_cache_hit : p0_cache_hit;
	endfunction

	function automatic logic stall_of(input bit p);
		return p ? p1_stall : p0_stall;
	endfunction

	function automatic logic err_of(input bit p);
		return p ? p1_err : p0_err;
	endfunction

	function automatic logic [DATA_W-1:0] data_of(input bit p);
		return p ? p1_data_out : p0_data_out;
	endfunction

	function automatic logic predict_hit(input bit p, input logic [ADDR_W-1:0] a);
		return shadow_valid[p][a[10:3]] && (shadow_tag[p][a[10:3]] == a[15:11]);
	endfunction

	task automatic update_model(input bit p, input logic wr, input logic [ADDR_W-1:0] a,
		input logic [DATA_W-1:0] d);
		// Every access leaves its block cached under write-allocate
		shadow_valid[p][a[10:3]] = 1'b1;
		shadow_tag[p][a[10:3]] = a[15:11];
		if (wr)
			ref_mem[a[15:1]] = d;
	endtask

	task automatic report_mismatch(input string name, input logic [DATA_W-1:0] expected,
		input logic [DATA_W-1:0] actual);
		errors++;
		$display("FAIL %s: expected %h, actual %h", name, expected, actual);
	endtask

	task automatic drive_port(input bit p, input logic r, input logic w,
		input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
		if (p)
		begin
			p1_rd <= r;
			p1_wr <= w;
			p1_addr <= a;
			p1_data_in <= d;
		end
		else
		begin
			p0_rd <= r;
			p0_wr <= w;
			p0_addr <= a;
			p0_data_in <= d;
		end
	endtask

	task automatic wait_done(input bit p, input string name, output logic [DATA_W-1:0] data,
		output logic hit, output int cycles);
		cycles = 0;
		@(negedge clk);
		while (done_of(p) !== 1'b1 && cycles <= 100)
		begin
			cycles++;
			@(negedge clk);
		end
		if (done_of(p) !== 1'b1)
		begin
			$display("Port %0d never raised done in %s", p, name);
			$display("Accesses: %0d, errors: %0d", accesses, errors + 1);
			$display("*** TEST FAILED ***");
			$finish;
		end
		else
		begin
			data = data_of(p);
			hit = hit_of(p);
		end
	endtask

	task automatic access_port(input bit p, input logic wr, input logic [ADDR_W-1:0] a,
		input logic [DATA_W-1:0] d, input string name);
		logic exp_hit;
		logic [DATA_W-1:0] exp_data;
		logic [DATA_W-1:0] got_data;
		logic got_hit;
		int cycles;
		exp_hit = predict_hit(p, a);
		exp_data = ref_mem[a[15:1]];
		@(posedge clk);
		drive_port(p, !wr, wr, a, d);
		wait_done(p, name, got_data, got_hit, cycles);
		@(posedge clk);
		drive_port(p, 1'b0, 1'b0, a, d);
		@(negedge clk);
		accesses++;
		if (got_hit !== exp_hit)
			report_mismatch({name, " cache_hit"}, 16'(exp_hit), 16'(got_hit));
		if (!wr && got_data !== exp_data)
			report_mismatch({name, " data"}, exp_data, got_data);
		// Hit path is IDLE, CMP, HIT
		if (exp_hit && cycles != 2)
			report_mismatch({name, " hit cycles"}, 16'd2, 16'(cycles));
		if (done_of(p) !== 1'b0)
		begin
			errors++;
			$display("Port %0d held done longer than one cycle in %s", p, name);
		end
		if (stall_of(p) !== 1'b0)
		begin
			errors++;
			$display("Port %0d kept stall high after returning to idle in %s", p, name);
		end
		update_model(p, wr, a, d);
	endtask

	task automatic check_read(input bit p, input logic [ADDR_W-1:0] a, input string name);
		access_port(p, 1'b0, a, '0, name);
	endtask

	task automatic rd_wr_collision(input bit p, input logic [ADDR_W-1:0] a,
		input string name);
		logic exp_hit;
		logic [DATA_W-1:0] exp_data;
		logic [DATA_W-1:0] got_data;
		logic got_hit;
		int cycles;
		exp_hit = predict_hit(p, a);
		exp_data = ref_mem[a[15:1]];
		@(posedge clk);
		drive_port(p, 1'b1, 1'b1, a, 16'hFFFF);
		@(negedge clk);
		if (err_of(p) !== 1'b1)
			report_mismatch({name, " err"}, 16'd1, 16'(err_of(p)));
		wait_done(p, name, got_data, got_hit, cycles);
		@(posedge clk);
		drive_port(p, 1'b0, 1'b0, a, '0);
		@(negedge clk);
		accesses++;
		if (err_of(p) !== 1'b0)
			report_mismatch({name, " err after release"}, 16'd0, 16'(err_of(p)));
		if (got_hit !== exp_hit)
			report_mismatch({name, " cache_hit"}, 16'(exp_hit), 16'(got_hit));
		if (got_data !== exp_data)
			report_mismatch({name, " data"}, exp_data, got_data);
		update_model(p, 1'b0, a, '0);
	endtask

	task automatic write_miss_read_hit();
		access_port(1'b0, 1'b1, 16'h0010, 16'h1234, "write_miss");
		check_read(1'b0, 16'h0010, "read_hit");
	endtask

	task automatic dirty_eviction();
		// Index 0x04 under tags 0 and 1
		access_port(1'b0, 1'b1, 16'h0020, 16'hA0A0, "evict_write_a");
		access_port(1'b0, 1'b1, 16'h0820, 16'hB0B0, "evict_write_b");
		check_read(1'b0, 16'h0020, "evict_read_a");
		check_read(1'b0, 16'h0820, "evict_read_b");
	endtask

	task automatic block_fill();
		logic [ADDR_W-1:0] a;
		for (int w = 0; w < 4; w++)
		begin
			a = 16'h0100 + 16'(2 * w);
			access_port(1'b0, 1'b1, a, a ^ 16'h3c5a, "fill_write");
		end
		// Tag 1 at the same index pushes the block out
		access_port(1'b0, 1'b1, 16'h0900, 16'h9999, "fill_evict");
		for (int w = 0; w < 4; w++)
			check_read(1'b0, 16'h0100 + 16'(2 * w), "fill_read");
	endtask

	task automatic port_contention();
		logic [ADDR_W-1:0] a [2];
		logic [DATA_W-1:0] exp_data [2];
		logic exp_hit [2];
		logic [1:0] fin;
		int cycles;
		a[0] = 16'h0200;
		a[1] = 16'h8200;
		// Dirty victims in both caches make both misses write back before the fill
		access_port(1'b0, 1'b1, a[0], 16'h0C0C, "contend_setup");
		access_port(1'b1, 1'b1, a[1], 16'h1C1C, "contend_setup");
		access_port(1'b0, 1'b1, 16'h0A00, 16'h0D0D, "contend_setup");
		access_port(1'b1, 1'b1, 16'h8A00, 16'h1D1D, "contend_setup");
		for (int i = 0; i < 2; i++)
		begin
			exp_data[i] = ref_mem[a[i][15:1]];
			exp_hit[i] = predict_hit(i[0], a[i]);
		end
		fin = 2'b00;
		cycles = 0;
		@(posedge clk);
		drive_port(1'b0, 1'b1, 1'b0, a[0], '0);
		drive_port(1'b1, 1'b1, 1'b0, a[1], '0);
		// Request cycle is still IDLE
		@(negedge clk);
		while (fin != 2'b11 && cycles < 100)
		begin
			@(posedge clk);
			for (int i = 0; i < 2; i++)
				if (fin[i])
					drive_port(i[0], 1'b0, 1'b0, a[i], '0);
			@(negedge clk);
			cycles++;
			for (int i = 0; i < 2; i++)
			begin
				if (!fin[i] && stall_of(i[0]) !== 1'b1)
				begin
					errors++;
					$display("Port %0d dropped stall before done in contention", i);
				end
				if (!fin[i] && done_of(i[0]) === 1'b1)
				begin
					fin[i] = 1'b1;
					accesses++;
					if (data_of(i[0]) !== exp_data[i])
						report_mismatch("contention data", exp_data[i], data_of(i[0]));
					if (hit_of(i[0]) !== exp_hit[i])
						report_mismatch("contention cache_hit", 16'(exp_hit[i]),
							16'(hit_of(i[0])));
				end
			end
		end
		if (fin != 2'b11)
		begin
			$display("Ports never both finished in contention, state %b", fin);
			$display("Accesses: %0d, errors: %0d", accesses, errors + 1);
			$display("*** TEST FAILED ***");
			$finish;
		end
		else
		begin
			@(posedge clk);
			drive_port(1'b0, 1'b0, 1'b0, a[0], '0);
			drive_port(1'b1, 1'b0, 1'b0, a[1], '0);
			update_model(1'b0, 1'b0, a[0], '0);
			update_model(1'b1, 1'b0, a[1], '0);
		end
	endtask

	task automatic random_traffic();
		logic [31:0] rnd;
		logic [ADDR_W-1:0] a;
		bit p;
		// Three tags on indexes 0x50 and 0x51 get written once before mixed traffic
		for (int q = 0; q < 2; q++)
			for (int t = 0; t < 3; t++)
				for (int k = 0; k < 8; k++)
				begin
					a = {5'(t + 16 * q), 7'h28, k[2], k[1:0], 1'b0};
					access_port(q[0], 1'b1, a, a ^ 16'h5a3c, "random_preload");
				end
		for (int n = 0; n < 200; n++)
		begin
			rnd = $random(seed);
			p = rnd[0];
			a = {5'(rnd[9:8] % 2'd3) + (p ? 5'd16 : 5'd0), 7'h28, rnd[4], rnd[3:2], 1'b0};
			if (rnd[1])
				access_port(p, 1'b1, a, rnd[31:16], "random_write");
			else
				check_read(p, a, "random_read");
		end
	endtask

	task automatic protocol_rules();
		// Both blocks still cached, read wins over write
		rd_wr_collision(1'b0, 16'h0010, "err_rd_and_wr p0");
		rd_wr_collision(1'b1, 16'h8200, "err_rd_and_wr p1");
		check_read(1'b1, 16'h8200, "hit_timing");
	endtask

	initial
	begin
		seed = 32'h428e;
		errors = 0;
		accesses = 0;
		clk = 1'b0;
		rst = 1'b1;
		p0_addr = '0;
		p0_data_in = '0;
		p0_rd = 1'b0;
		p0_wr = 1'b0;
		p1_addr = '0;
		p1_data_in = '0;
		p1_rd = 1'b0;
		p1_wr = 1'b0;
		shadow_valid[0] = '0;
		shadow_valid[1] = '0;

		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		if (p0_stall !== 1'b0)
			report_mismatch("stall_after_reset p0", 16'd0, 16'(p0_stall));
		if (p1_stall !== 1'b0)
			report_mismatch("stall_after_reset p1", 16'd0, 16'(p1_stall));
		if (p0_done !== 1'b0 || p1_done !== 1'b0)
			report_mismatch("done_after_reset", 16'd0, 16'({p1_done, p0_done}));

		write_miss_read_hit();
		dirty_eviction();
		block_fill();
		port_contention();
		random_traffic();
		protocol_rules();

		$display("Accesses: %0d, errors: %0d", accesses, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
